//--- filelist.f
+incdir+include
source/mipsPkg.sv
source/regFile.sv
source/fetchStage.sv
source/decodeStage.sv
source/hazardUnit.sv
source/executeStage.sv
source/memWbStage.sv
source/mipsCore.sv
tests/coreTb.sv

//--- include/testProgram.svh
/* Program image and expected stores for the core testbench.
   Include after importing mipsPkg. The program starts at address zero and ends in
   a J loop; stores on skipped branch paths are absent from storeTable. */
`ifndef TEST_PROGRAM_SVH
`define TEST_PROGRAM_SVH

localparam int programLen = 46;

localparam logic [dataWidth-1:0] programWords [programLen] = '{
    // Immediates: r1=5, r2=-3, r3=0x8001 (zero-extended)
    32'h24010005, 32'h2402FFFD, 32'h34038001,
    // ADDU, SUBU, AND, OR, SLT, SLT into r4..r9
    32'h00222021, 32'h00412823, 32'h00613024, 32'h00623825, 32'h0041402A, 32'h0022482A,
    // Store r1..r9 to words 0x10..0x18
    32'hAC010040, 32'hAC020044, 32'hAC030048, 32'hAC04004C, 32'hAC050050,
    32'hAC060054, 32'hAC070058, 32'hAC08005C, 32'hAC090060,
    // Dependent chain r10..r13, stores r13 then r12
    32'h240A0007, 32'h014A5821, 32'h016A6023, 32'h018B6825, 32'hAC0D0064, 32'hAC0C0068,
    // Load-use into ADDU, then load straight into a store
    32'h8C0F0040, 32'h01EF8021, 32'hAC10006C, 32'h8C110044, 32'hAC110070,
    // BEQ taken, slot store, skipped store
    32'h10210002, 32'hAC010074, 32'hAC020078,
    // BNE not taken, slot store, fall-through store
    32'h14210003, 32'hAC03007C, 32'hAC040080,
    // BNE on a fresh register, slot store, skipped store
    32'h24120001, 32'h16400002, 32'hAC120084, 32'hAC020088,
    // J, slot store, skipped store
    32'h0800002A, 32'hAC05008C, 32'hAC020090,
    // Write to r0 then store r0, then park in a J loop
    32'h24000055, 32'hAC000094, 32'h0800002C, 32'h00000000
};

typedef struct packed {
    logic [wordAddrWidth-1:0] addr;
    logic [dataWidth-1:0]     data;
} storeEntryT;

localparam int storeCount = 19;

// In program order
localparam storeEntryT storeTable [storeCount] = '{
    '{30'h10, 32'h00000005}, '{30'h11, 32'hFFFFFFFD}, '{30'h12, 32'h00008001},
    '{30'h13, 32'h00000002}, '{30'h14, 32'hFFFFFFF8}, '{30'h15, 32'h00000001},
    '{30'h16, 32'hFFFFFFFD}, '{30'h17, 32'h00000001}, '{30'h18, 32'h00000000},
    '{30'h19, 32'h0000000F}, '{30'h1A, 32'h00000007}, '{30'h1B, 32'h0000000A},
    '{30'h1C, 32'hFFFFFFFD}, '{30'h1D, 32'h00000005}, '{30'h1F, 32'h00008001},
    '{30'h20, 32'h00000002}, '{30'h21, 32'h00000001}, '{30'h23, 32'hFFFFFFF8},
    '{30'h25, 32'h00000000}
};

`endif

//--- tests/coreTb.sv
/* Testbench for the MIPS32 subset core with combinational memory models.
   Inputs are driven on the falling edge; stores are checked in program order
   against storeTable. The run ends once the core parks in its final J loop. */
`timescale 1ns/1ns

module coreTb
    import mipsPkg::*;
();
    `include "testProgram.svh"

    localparam logic [dataWidth-1:0] resetPc = '0;
    localparam int clkPeriod   = 100;
    localparam int resetCycles = 3;
    localparam int dataWords   = 64;
    // Final J loops on itself with its slot after it
    localparam int parkAddr    = programLen - 2;
    // Last store still has to leave decode, execute and memory
    localparam int drainCycles = 6;
    localparam int watchdogCycles = 4 * programLen + 20;

    logic                      clk = 1'b0;
    logic                      rstN;
    logic [wordAddrWidth-1:0]  instAddr;
    logic [dataWidth-1:0]      instData;
    logic [wordAddrWidth-1:0]  dataAddr;
    logic                      dataRead;
    logic                      dataWrite;
    logic [dataWidth-1:0]      dataOut;
    logic [dataWidth-1:0]      dataIn;

    logic [dataWidth-1:0] instMem [programLen];
    logic [dataWidth-1:0] dataMem [dataWords];
    int                   storeIdx;
    logic                 memSeen;

    mipsCore #(.resetPc(resetPc)) DUT (
        .clk       (clk),
        .rstN      (rstN),
        .instAddr  (instAddr),
        .instData  (instData),
        .dataAddr  (dataAddr),
        .dataRead  (dataRead),
        .dataWrite (dataWrite),
        .dataOut   (dataOut),
        .dataIn    (dataIn)
    );

    initial
    begin
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic checkAddr(input string name, input logic [wordAddrWidth-1:0] got,
                             input logic [wordAddrWidth-1:0] expected);
        if (got !== expected)
        begin
            $display("ERR %0t %s: got %h expected %h", $time, name, got, expected);
            abortRun("word address mismatch");
        end
    endtask

    task automatic checkWord(input string name, input logic [dataWidth-1:0] got,
                             input logic [dataWidth-1:0] expected);
        if (got !== expected)
        begin
            $display("ERR %0t %s: got %h expected %h", $time, name, got, expected);
            abortRun("data word mismatch");
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic expected);
        if (got !== expected)
        begin
            $display("ERR %0t %s: got %b expected %b", $time, name, got, expected);
            abortRun("strobe mismatch");
        end
    endtask

    // Background pattern over the full word address
    function automatic logic [dataWidth-1:0] fillWord(input logic [wordAddrWidth-1:0] addr);
        return {addr, 2'b00} ^ 32'hC3A50F96;
    endfunction

    function automatic logic [dataWidth-1:0] fetchWord(input logic [wordAddrWidth-1:0] addr);
        if (addr < programLen)
            return instMem[addr];
        return '0;
    endfunction

    function automatic logic [dataWidth-1:0] readData(input logic [wordAddrWidth-1:0] addr);
        if (addr < dataWords)
            return dataMem[addr];
        return fillWord(addr);
    endfunction

    // Memory models and the in-order store check
    always @(negedge clk)
    begin
        instData = fetchWord(instAddr);
        if (!memSeen)
            checkFlag("dataRead", dataRead, 1'b0);
        if (dataRead)
            dataIn = readData(dataAddr);
        else
            dataIn = '0;
        if (dataWrite)
        begin
            memSeen = 1'b1;
            if (storeIdx >= storeCount)
                abortRun($sformatf("Unexpected extra store to word %h", dataAddr));
            checkAddr("dataAddr", dataAddr, storeTable[storeIdx].addr);
            checkWord("dataOut", dataOut, storeTable[storeIdx].data);
            if (dataAddr < dataWords)
                dataMem[dataAddr] = dataOut;
            storeIdx = storeIdx + 1;
        end
    end

    initial
    begin
        #(clkPeriod * (resetCycles + watchdogCycles));
        abortRun($sformatf("Timeout: core never reached the final loop, %0d of %0d stores seen",
                           storeIdx, storeCount));
    end

    initial
    begin
        rstN     = 1'b0;
        instData = '0;
        dataIn   = '0;
        storeIdx = 0;
        memSeen  = 1'b0;
        for (int i = 0; i < programLen; i++)
            instMem[i] = programWords[i];
        for (int i = 0; i < dataWords; i++)
            dataMem[i] = fillWord(wordAddrWidth'(i));

        // PC parked at the reset address with no memory strobes
        repeat (resetCycles)
        begin
            @(negedge clk);
            checkAddr("instAddr", instAddr, resetPc[dataWidth-1:2]);
            checkFlag("dataRead", dataRead, 1'b0);
            checkFlag("dataWrite", dataWrite, 1'b0);
        end
        rstN = 1'b1;

        while (instAddr !== wordAddrWidth'(parkAddr))
            @(negedge clk);
        repeat (drainCycles) @(negedge clk);

        if (storeIdx != storeCount)
            abortRun($sformatf("Missing stores: %0d of %0d seen", storeIdx, storeCount));
        else
        begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- source/mipsCore.sv
/* Five-stage MIPS32 subset core with one branch delay slot.
   Both memories must answer combinationally within the cycle; there is no
   back-pressure. Addresses on both ports are word addresses. */
`timescale 1ns/1ns

module mipsCore
    import mipsPkg::*;
#(
    parameter logic [dataWidth-1:0] resetPc = '0
)
(
    input  logic                      clk,
    input  logic                      rstN,
    output logic [wordAddrWidth-1:0]  instAddr,
    input  logic [dataWidth-1:0]      instData,
    output logic [wordAddrWidth-1:0]  dataAddr,
    output logic                      dataRead,
    output logic                      dataWrite,
    output logic [dataWidth-1:0]      dataOut,
    input  logic [dataWidth-1:0]      dataIn
);
    // Fetch to decode
    logic [dataWidth-1:0]     idInstr;
    logic [dataWidth-1:0]     idPcPlus4;
    logic                     takeTarget;
    logic [dataWidth-1:0]     target;

    // Decode side hazard info
    logic [regAddrWidth-1:0]  idRs;
    logic [regAddrWidth-1:0]  idRt;
    logic                     usesRs;
    logic                     usesRt;
    logic                     isBranch;
    logic                     stall;
    fwdSelT                   idFwdA;
    fwdSelT                   idFwdB;
    fwdSelT                   exFwdA;
    fwdSelT                   exFwdB;

    // Decode/execute register
    aluOpT                    exAluOp;
    logic [dataWidth-1:0]     exOpA;
    logic [dataWidth-1:0]     exOpB;
    logic [dataWidth-1:0]     exStoreData;
    logic [regAddrWidth-1:0]  exRs;
    logic [regAddrWidth-1:0]  exRt;
    logic [regAddrWidth-1:0]  exDest;
    logic                     exRegWrite;
    logic                     exMemRead;
    logic                     exMemWrite;

    // Execute/memory and writeback
    logic [dataWidth-1:0]     memResult;
    logic [dataWidth-1:0]     memStoreData;
    logic [regAddrWidth-1:0]  memDest;
    logic                     memRegWrite;
    logic                     memMemRead;
    logic                     memMemWrite;
    logic [dataWidth-1:0]     wbValue;
    logic [regAddrWidth-1:0]  wbDest;
    logic                     wbRegWrite;

    fetchStage #(.resetPc(resetPc)) fetch (
        .clk        (clk),
        .rstN       (rstN),
        .stall      (stall),
        .takeTarget (takeTarget),
        .target     (target),
        .instData   (instData),
        .instAddr   (instAddr),
        .idInstr    (idInstr),
        .idPcPlus4  (idPcPlus4)
    );

    decodeStage decode (
        .clk         (clk),
        .rstN        (rstN),
        .stall       (stall),
        .idInstr     (idInstr),
        .idPcPlus4   (idPcPlus4),
        .idFwdA      (idFwdA),
        .idFwdB      (idFwdB),
        .memResult   (memResult),
        .wbValue     (wbValue),
        .wbDest      (wbDest),
        .wbRegWrite  (wbRegWrite),
        .takeTarget  (takeTarget),
        .target      (target),
        .idRs        (idRs),
        .idRt        (idRt),
        .usesRs      (usesRs),
        .usesRt      (usesRt),
        .isBranch    (isBranch),
        .exAluOp     (exAluOp),
        .exOpA       (exOpA),
        .exOpB       (exOpB),
        .exStoreData (exStoreData),
        .exRs        (exRs),
        .exRt        (exRt),
        .exDest      (exDest),
        .exRegWrite  (exRegWrite),
        .exMemRead   (exMemRead),
        .exMemWrite  (exMemWrite)
    );

    hazardUnit hazard (
        .idRs        (idRs),
        .idRt        (idRt),
        .usesRs      (usesRs),
        .usesRt      (usesRt),
        .isBranch    (isBranch),
        .exDest      (exDest),
        .exRegWrite  (exRegWrite),
        .exMemRead   (exMemRead),
        .exRs        (exRs),
        .exRt        (exRt),
        .memDest     (memDest),
        .memRegWrite (memRegWrite),
        .memMemRead  (memMemRead),
        .wbDest      (wbDest),
        .wbRegWrite  (wbRegWrite),
        .stall       (stall),
        .idFwdA      (idFwdA),
        .idFwdB      (idFwdB),
        .exFwdA      (exFwdA),
        .exFwdB      (exFwdB)
    );

    executeStage execute (
        .clk          (clk),
        .rstN         (rstN),
        .exAluOp      (exAluOp),
        .exOpA        (exOpA),
        .exOpB        (exOpB),
        .exStoreData  (exStoreData),
        .exRegWrite   (exRegWrite),
        .exMemRead    (exMemRead),
        .exMemWrite   (exMemWrite),
        .exDest       (exDest),
        .exFwdA       (exFwdA),
        .exFwdB       (exFwdB),
        .wbValue      (wbValue),
        .memResult    (memResult),
        .memStoreData (memStoreData),
        .memDest      (memDest),
        .memRegWrite  (memRegWrite),
        .memMemRead   (memMemRead),
        .memMemWrite  (memMemWrite)
    );

    memWbStage memWb (
        .clk          (clk),
        .rstN         (rstN),
        .memResult    (memResult),
        .memStoreData (memStoreData),
        .memDest      (memDest),
        .memRegWrite  (memRegWrite),
        .memMemRead   (memMemRead),
        .memMemWrite  (memMemWrite),
        .dataIn       (dataIn),
        .dataAddr     (dataAddr),
        .dataRead     (dataRead),
        .dataWrite    (dataWrite),
        .dataOut      (dataOut),
        .wbValue      (wbValue),
        .wbDest       (wbDest),
        .wbRegWrite   (wbRegWrite)
    );

endmodule

//--- source/memWbStage.sv
/* Data memory port and the memory/writeback register.
   dataIn is taken at the edge that closes the memory stage; no wait states. */
`timescale 1ns/1ns

module memWbStage
    import mipsPkg::*;
(
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [dataWidth-1:0]      memResult,
    input  logic [dataWidth-1:0]      memStoreData,
    input  logic [regAddrWidth-1:0]   memDest,
    input  logic                      memRegWrite,
    input  logic                      memMemRead,
    input  logic                      memMemWrite,
    input  logic [dataWidth-1:0]      dataIn,
    output logic [wordAddrWidth-1:0]  dataAddr,
    output logic                      dataRead,
    output logic                      dataWrite,
    output logic [dataWidth-1:0]      dataOut,
    output logic [dataWidth-1:0]      wbValue,
    output logic [regAddrWidth-1:0]   wbDest,
    output logic                      wbRegWrite
);
    // Word access only, byte offset bits dropped
    assign dataAddr  = memResult[dataWidth-1:2];
    assign dataRead  = memMemRead;
    assign dataWrite = memMemWrite;
    assign dataOut   = memStoreData;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            wbDest     <= '0;
            wbRegWrite <= 1'b0;
        end
        else
        begin
            wbDest     <= memDest;
            wbRegWrite <= memRegWrite;
        end
    end

    always_ff @(posedge clk)
    begin
        wbValue <= memMemRead ? dataIn : memResult;
    end

    readWriteExclusive: assert property (
        @(posedge clk) disable iff (!rstN) !(dataRead && dataWrite)
    );

endmodule

//--- source/executeStage.sv
/* Execute forwarding, ALU and the execute/memory register.
   SLT compares signed; ADDU and SUBU wrap without overflow traps. */
`timescale 1ns/1ns

module executeStage
    import mipsPkg::*;
(
    input  logic                     clk,
    input  logic                     rstN,
    input  aluOpT                    exAluOp,
    input  logic [dataWidth-1:0]     exOpA,
    input  logic [dataWidth-1:0]     exOpB,
    input  logic [dataWidth-1:0]     exStoreData,
    input  logic                     exRegWrite,
    input  logic                     exMemRead,
    input  logic                     exMemWrite,
    input  logic [regAddrWidth-1:0]  exDest,
    input  fwdSelT                   exFwdA,
    input  fwdSelT                   exFwdB,
    input  logic [dataWidth-1:0]     wbValue,
    output logic [dataWidth-1:0]     memResult,
    output logic [dataWidth-1:0]     memStoreData,
    output logic [regAddrWidth-1:0]  memDest,
    output logic                     memRegWrite,
    output logic                     memMemRead,
    output logic                     memMemWrite
);
    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] storeValue;
    logic [dataWidth-1:0] aluResult;

    assign opA        = selectOperand(exFwdA, exOpA, memResult, wbValue);
    assign storeValue = selectOperand(exFwdB, exStoreData, memResult, wbValue);
    // A store keeps its offset on B; rt only feeds the store data
    assign opB = exMemWrite ? exOpB : selectOperand(exFwdB, exOpB, memResult, wbValue);

    always_comb
    begin
        case (exAluOp)
            aluSub:  aluResult = opA - opB;
            aluAnd:  aluResult = opA & opB;
            aluOr:   aluResult = opA | opB;
            aluSlt:  aluResult = {{(dataWidth-1){1'b0}}, $signed(opA) < $signed(opB)};
            default: aluResult = opA + opB;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            memDest     <= '0;
            memRegWrite <= 1'b0;
            memMemRead  <= 1'b0;
            memMemWrite <= 1'b0;
        end
        else
        begin
            memDest     <= exDest;
            memRegWrite <= exRegWrite;
            memMemRead  <= exMemRead;
            memMemWrite <= exMemWrite;
        end
    end

    always_ff @(posedge clk)
    begin
        memResult    <= aluResult;
        memStoreData <= storeValue;
    end

    storeNeverWritesReg: assert property (
        @(posedge clk) disable iff (!rstN) !(exMemWrite && exRegWrite)
    );

endmodule

//--- source/hazardUnit.sv
/* Forward selects for decode and execute, plus the one-cycle stall.
   A load in memory cannot forward; its consumers pick it up from writeback. */
`timescale 1ns/1ns

module hazardUnit
    import mipsPkg::*;
(
    input  logic [regAddrWidth-1:0]  idRs,
    input  logic [regAddrWidth-1:0]  idRt,
    input  logic                     usesRs,
    input  logic                     usesRt,
    input  logic                     isBranch,
    input  logic [regAddrWidth-1:0]  exDest,
    input  logic                     exRegWrite,
    input  logic                     exMemRead,
    input  logic [regAddrWidth-1:0]  exRs,
    input  logic [regAddrWidth-1:0]  exRt,
    input  logic [regAddrWidth-1:0]  memDest,
    input  logic                     memRegWrite,
    input  logic                     memMemRead,
    input  logic [regAddrWidth-1:0]  wbDest,
    input  logic                     wbRegWrite,
    output logic                     stall,
    output fwdSelT                   idFwdA,
    output fwdSelT                   idFwdB,
    output fwdSelT                   exFwdA,
    output fwdSelT                   exFwdB
);
    // Memory stage wins over writeback
    function automatic fwdSelT pickSource(input logic [regAddrWidth-1:0] src);
        if (src == '0)
            return fwdReg;
        if (memRegWrite && !memMemRead && memDest == src)
            return fwdMem;
        if (wbRegWrite && wbDest == src)
            return fwdWb;
        return fwdReg;
    endfunction

    // Decode instruction reads this register
    function automatic logic readsReg(input logic [regAddrWidth-1:0] dest);
        return dest != '0 && ((usesRs && dest == idRs) || (usesRt && dest == idRt));
    endfunction

    always_comb
    begin
        idFwdA = pickSource(idRs);
        idFwdB = pickSource(idRt);
        exFwdA = pickSource(exRs);
        exFwdB = pickSource(exRt);
        stall  = (exMemRead && readsReg(exDest))
              || (isBranch && exRegWrite && readsReg(exDest))
              || (isBranch && memMemRead && readsReg(memDest));
    end

endmodule

//--- source/decodeStage.sv
/* Decode, register read, branch resolution and the decode/execute register.
   BEQ, BNE and J redirect at the end of this stage with one delay slot.
   Unknown opcodes and function codes leave no write, load or store behind. */
`timescale 1ns/1ns

module decodeStage
    import mipsPkg::*;
(
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     stall,
    input  logic [dataWidth-1:0]     idInstr,
    input  logic [dataWidth-1:0]     idPcPlus4,
    input  fwdSelT                   idFwdA,
    input  fwdSelT                   idFwdB,
    input  logic [dataWidth-1:0]     memResult,
    input  logic [dataWidth-1:0]     wbValue,
    input  logic [regAddrWidth-1:0]  wbDest,
    input  logic                     wbRegWrite,
    output logic                     takeTarget,
    output logic [dataWidth-1:0]     target,
    output logic [regAddrWidth-1:0]  idRs,
    output logic [regAddrWidth-1:0]  idRt,
    output logic                     usesRs,
    output logic                     usesRt,
    output logic                     isBranch,
    output aluOpT                    exAluOp,
    output logic [dataWidth-1:0]     exOpA,
    output logic [dataWidth-1:0]     exOpB,
    output logic [dataWidth-1:0]     exStoreData,
    output logic [regAddrWidth-1:0]  exRs,
    output logic [regAddrWidth-1:0]  exRt,
    output logic [regAddrWidth-1:0]  exDest,
    output logic                     exRegWrite,
    output logic                     exMemRead,
    output logic                     exMemWrite
);
    opcodeT                   opcode;
    functT                    funct;
    logic [15:0]              imm;
    logic [regAddrWidth-1:0]  rd;
    logic [regAddrWidth-1:0]  dest;
    aluOpT                    aluOp;
    logic                     useImm;
    logic                     zeroExt;
    logic                     isJump;
    logic                     regWrite;
    logic                     memRead;
    logic                     memWrite;
    logic [dataWidth-1:0]     regA;
    logic [dataWidth-1:0]     regB;
    logic [dataWidth-1:0]     rsValue;
    logic [dataWidth-1:0]     rtValue;
    logic [dataWidth-1:0]     immValue;
    logic                     operandsEqual;

    assign opcode = opcodeT'(idInstr[31:26]);
    assign funct  = functT'(idInstr[5:0]);
    assign idRs   = idInstr[25:21];
    assign idRt   = idInstr[20:16];
    assign rd     = idInstr[15:11];
    assign imm    = idInstr[15:0];

    always_comb
    begin
        aluOp    = aluAdd;
        useImm   = 1'b0;
        zeroExt  = 1'b0;
        dest     = idRt;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        usesRs   = 1'b0;
        usesRt   = 1'b0;
        isBranch = 1'b0;
        isJump   = 1'b0;
        case (opcode)
            opRtype:
            begin
                dest     = rd;
                regWrite = 1'b1;
                usesRs   = 1'b1;
                usesRt   = 1'b1;
                case (funct)
                    fnAddu: aluOp = aluAdd;
                    fnSubu: aluOp = aluSub;
                    fnAnd:  aluOp = aluAnd;
                    fnOr:   aluOp = aluOr;
                    fnSlt:  aluOp = aluSlt;
                    default:
                    begin
                        regWrite = 1'b0;
                        usesRs   = 1'b0;
                        usesRt   = 1'b0;
                    end
                endcase
            end
            opAddiu, opLw:
            begin
                useImm   = 1'b1;
                regWrite = 1'b1;
                memRead  = (opcode == opLw);
                usesRs   = 1'b1;
            end
            opOri:
            begin
                aluOp    = aluOr;
                useImm   = 1'b1;
                zeroExt  = 1'b1;
                regWrite = 1'b1;
                usesRs   = 1'b1;
            end
            opSw:
            begin
                useImm   = 1'b1;
                memWrite = 1'b1;
                usesRs   = 1'b1;
                usesRt   = 1'b1;
            end
            opBeq, opBne:
            begin
                usesRs   = 1'b1;
                usesRt   = 1'b1;
                isBranch = 1'b1;
            end
            opJ:     isJump = 1'b1;
            default: ;
        endcase
    end

    regFile regs (
        .clk       (clk),
        .readA     (idRs),
        .readB     (idRt),
        .writeAddr (wbDest),
        .writeData (wbValue),
        .writeEn   (wbRegWrite),
        .dataA     (regA),
        .dataB     (regB)
    );

    assign rsValue  = selectOperand(idFwdA, regA, memResult, wbValue);
    assign rtValue  = selectOperand(idFwdB, regB, memResult, wbValue);
    assign immValue = zeroExt ? {16'b0, imm} : {{16{imm[15]}}, imm};

    // Branch compare and redirect
    assign operandsEqual = (rsValue == rtValue);
    assign takeTarget = isJump
                     || (opcode == opBeq && operandsEqual)
                     || (opcode == opBne && !operandsEqual);
    assign target = isJump ? {idPcPlus4[31:28], idInstr[25:0], 2'b00}
                           : idPcPlus4 + {immValue[dataWidth-3:0], 2'b00};

    // Stall drops a bubble into execute
    always_ff @(posedge clk)
    begin
        if (!rstN || stall)
        begin
            exAluOp    <= aluAdd;
            exRs       <= '0;
            exRt       <= '0;
            exDest     <= '0;
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
        end
        else
        begin
            exAluOp    <= aluOp;
            // Unused sources go in as r0 so execute never forwards into them
            exRs       <= usesRs ? idRs : '0;
            exRt       <= usesRt ? idRt : '0;
            exDest     <= dest;
            exRegWrite <= regWrite;
            exMemRead  <= memRead;
            exMemWrite <= memWrite;
        end
    end

    always_ff @(posedge clk)
    begin
        exOpA       <= rsValue;
        exOpB       <= useImm ? immValue : rtValue;
        exStoreData <= rtValue;
    end

endmodule

//--- source/fetchStage.sv
/* Program counter and fetch/decode register.
   instData must be valid before the next rising edge. The delay-slot word is
   already in fetch when a redirect arrives, so it is never squashed. */
`timescale 1ns/1ns

module fetchStage
    import mipsPkg::*;
#(
    parameter logic [dataWidth-1:0] resetPc = '0
)
(
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      stall,
    input  logic                      takeTarget,
    input  logic [dataWidth-1:0]      target,
    input  logic [dataWidth-1:0]      instData,
    output logic [wordAddrWidth-1:0]  instAddr,
    output logic [dataWidth-1:0]      idInstr,
    output logic [dataWidth-1:0]      idPcPlus4
);
    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] pcPlus4;
    logic [dataWidth-1:0] nextPc;

    assign pcPlus4  = pc + dataWidth'(4);
    assign nextPc   = takeTarget ? target : pcPlus4;
    assign instAddr = pc[dataWidth-1:2];

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            pc        <= resetPc;
            // All-zero word decodes as a no-operation
            idInstr   <= '0;
            idPcPlus4 <= '0;
        end
        else if (!stall)
        begin
            pc        <= nextPc;
            idInstr   <= instData;
            idPcPlus4 <= pcPlus4;
        end
    end

    pcHoldsOnStall: assert property (
        @(posedge clk) disable iff (!rstN) stall |=> $stable(pc)
    );

endmodule

//--- source/regFile.sv
/* General register file with two asynchronous reads and one write port.
   A read in the cycle of a write returns the old value. */
`timescale 1ns/1ns

module regFile
    import mipsPkg::*;
(
    input  logic                     clk,
    input  logic [regAddrWidth-1:0]  readA,
    input  logic [regAddrWidth-1:0]  readB,
    input  logic [regAddrWidth-1:0]  writeAddr,
    input  logic [dataWidth-1:0]     writeData,
    input  logic                     writeEn,
    output logic [dataWidth-1:0]     dataA,
    output logic [dataWidth-1:0]     dataB
);
    logic [dataWidth-1:0] regs [numRegs];

    always_ff @(posedge clk)
    begin
        if (writeEn && writeAddr != '0)
            regs[writeAddr] <= writeData;
    end

    // r0 is hardwired to zero
    assign dataA = (readA == '0) ? '0 : regs[readA];
    assign dataB = (readB == '0) ? '0 : regs[readB];

endmodule

//--- source/mipsPkg.sv
/* Shared widths and encodings for the MIPS32 subset core.
   Opcode and function values follow the MIPS32 encoding; anything else decodes
   as a no-operation. */
package mipsPkg;

    localparam int dataWidth     = 32;
    localparam int wordAddrWidth = 30;
    localparam int regAddrWidth  = 5;
    localparam int numRegs       = 32;

    typedef enum logic [5:0] {
        opRtype = 6'h00,
        opJ     = 6'h02,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opAddiu = 6'h09,
        opOri   = 6'h0d,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcodeT;

    typedef enum logic [5:0] {
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnSlt  = 6'h2a
    } functT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpT;

    // Operand source picked by the hazard unit
    typedef enum logic [1:0] {
        fwdReg,
        fwdMem,
        fwdWb
    } fwdSelT;

    function automatic logic [dataWidth-1:0] selectOperand(
        input fwdSelT                 sel,
        input logic [dataWidth-1:0]   regValue,
        input logic [dataWidth-1:0]   memValue,
        input logic [dataWidth-1:0]   wbValue
    );
        case (sel)
            fwdMem:  return memValue;
            fwdWb:   return wbValue;
            default: return regValue;
        endcase
    endfunction

endpackage
